/* design/cpu_io_defines.svh */
// cpu io constants
// op-bit positions, control-bit positions, serial-select codes and
// the id and version words shown in the status register

`ifndef CPU_IO_DEFINES_SVH
`define CPU_IO_DEFINES_SVH

// bus widths
`define CPU_OP_W        16
`define CPU_TOS_W       32
`define CPU_PAR_W       16
`define CPU_CTR_W       32
`define CTRL_W          13

// op word bit positions, one-hot
`define OP_SET_CTRL      0
`define OP_GET_STATUS    1
`define OP_GET_SRQ       2
`define OP_GET_CPU_CTR0  3
`define OP_GET_CPU_CTR1  4
`define OP_GET_CPU_CTR2  5
`define OP_GET_CPU_CTR3  6
// used with rd_reg2
`define OP_GET_ADC_CTR0  7
`define OP_GET_ADC_CTR1  8
// used with wr_evt2
`define OP_CPU_CTR_CLR   9
`define OP_CPU_CTR_ENA  10
`define OP_CPU_CTR_DIS  11

// control word bit positions, match ctrl_word_t
`define CTRL_OSC_EN     12
`define CTRL_STEN       11
`define CTRL_SER_SEL_HI 10
`define CTRL_SER_SEL_LO  9
`define CTRL_SER_LE_CSN  8
`define CTRL_SER_CLK     7
`define CTRL_SER_DATA    6
`define CTRL_EEPROM_WP   5
`define CTRL_CMD_READY   4
`define CTRL_SND_INTR    3
`define CTRL_UNUSED_OUT  2
`define CTRL_USE_GEN     1
`define CTRL_GEN_FIR     0

// serial select codes, 2'd0 selects nothing
`define SER_ATTN        2'd1
`define SER_GPS         2'd2
`define SER_DNA         2'd3

`define FPGA_ID         4'h5
`define FPGA_VER        4'h3

`endif

/* design/cpu_io_pkg.sv */
// cpu io types
// packed structs passed between the decode, state and read stages

`default_nettype none

package cpu_io_pkg;

    // global control register, msb first
    typedef struct packed {
        logic       osc_en;
        logic       sten;
        logic [1:0] ser_sel;
        logic       ser_le_csn;
        logic       ser_clk;
        logic       ser_data;
        logic       eeprom_wp;
        logic       cmd_ready;
        logic       snd_intr;
        logic       unused_out;
        logic       use_gen;
        logic       gen_fir;
    } ctrl_word_t;

    // one decoded cpu operation per cycle
    typedef struct packed {
        logic       set_ctrl;
        ctrl_word_t ctrl_data;
        logic       get_status;
        logic       get_srq;
        // one-hot byte lane of the counters
        logic [3:0] get_ctr;
        logic       get_adc_lo;
        logic       get_adc_hi;
        logic       ctr_clr;
        logic       ctr_ena;
        logic       ctr_dis;
    } cpu_cmd_t;

    // one bit-banged serial target
    typedef struct packed {
        logic le_csn;
        logic clk;
        logic data;
    } ser_bus_t;

    typedef struct packed {
        logic       overflow;
        logic [2:0] reserved;
        logic [3:0] fpga_ver;
        logic [3:0] user;
        logic [3:0] fpga_id;
    } status_word_t;

endpackage

`default_nettype wire

/* design/cpu_cmd_decode.sv */
// cpu command decode, stage one
// qualifies the register strobes with the op bits and registers one
// decoded command per cycle

`default_nettype none

`include "cpu_io_defines.svh"

module cpu_cmd_decode
    import cpu_io_pkg::*;
(
    input  logic                  cpu_clk,
    input  logic                  rx_orst,
    input  logic [`CPU_OP_W-1:0]  op,
    input  logic [`CPU_TOS_W-1:0] tos,
    input  logic                  rd_reg,
    input  logic                  rd_reg2,
    input  logic                  wr_reg,
    input  logic                  wr_evt2,
    output cpu_cmd_t              cmd
);

    cpu_cmd_t cmd_d;

    // strobe and op bit on the same edge
    always_comb
    begin
        cmd_d            = '0;
        // write to the control register
        cmd_d.set_ctrl   = wr_reg & op[`OP_SET_CTRL];
        cmd_d.ctrl_data  = tos[`CTRL_W-1:0];
        // plain register reads
        cmd_d.get_status = rd_reg & op[`OP_GET_STATUS];
        cmd_d.get_srq    = rd_reg & op[`OP_GET_SRQ];
        cmd_d.get_ctr    = {rd_reg & op[`OP_GET_CPU_CTR3],
                            rd_reg & op[`OP_GET_CPU_CTR2],
                            rd_reg & op[`OP_GET_CPU_CTR1],
                            rd_reg & op[`OP_GET_CPU_CTR0]};
        // adc count halves sit on the second read strobe
        cmd_d.get_adc_lo = rd_reg2 & op[`OP_GET_ADC_CTR0];
        cmd_d.get_adc_hi = rd_reg2 & op[`OP_GET_ADC_CTR1];
        // counter events
        cmd_d.ctr_clr    = wr_evt2 & op[`OP_CPU_CTR_CLR];
        cmd_d.ctr_ena    = wr_evt2 & op[`OP_CPU_CTR_ENA];
        cmd_d.ctr_dis    = wr_evt2 & op[`OP_CPU_CTR_DIS];
    end

    // single pipeline register
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
            cmd <= '0;
        else
            cmd <= cmd_d;
    end

endmodule

`default_nettype wire

/* design/ctrl_reg_bank.sv */
// global control register, stage two
// holds the control word, steers the shared serial lines to one target
// and drives the board control pins

`default_nettype none

`include "cpu_io_defines.svh"

module ctrl_reg_bank
    import cpu_io_pkg::*;
(
    input  logic       cpu_clk,
    input  logic       rx_orst,
    input  cpu_cmd_t   cmd,
    output ctrl_word_t ctrl,
    output ser_bus_t   attn_bus,
    output ser_bus_t   gps_bus,
    output ser_bus_t   dna_bus,
    output logic       adc_clken,
    output logic       adc_stenl,
    output logic       ewp,
    output logic       cmd_ready,
    output logic       snd_intr
);

    ser_bus_t ser_bits;

    //////////////////////////////
    // control register
    //////////////////////////////

    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
            ctrl <= '0;
        else if (cmd.set_ctrl)
            ctrl <= cmd.ctrl_data;
    end

    //////////////////////////////
    // serial routing
    //////////////////////////////

    // the three bit-banged lines as one bus
    assign ser_bits.le_csn = ctrl.ser_le_csn;
    assign ser_bits.clk    = ctrl.ser_clk;
    assign ser_bits.data   = ctrl.ser_data;

    // unselected targets held low
    assign attn_bus = (ctrl.ser_sel == `SER_ATTN) ? ser_bits : '0;
    assign gps_bus  = (ctrl.ser_sel == `SER_GPS)  ? ser_bits : '0;
    assign dna_bus  = (ctrl.ser_sel == `SER_DNA)  ? ser_bits : '0;

    //////////////////////////////
    // control pins
    //////////////////////////////

    assign adc_clken = ctrl.osc_en;
    // adc self-test enable is active low
    assign adc_stenl = ~ctrl.sten;
    assign ewp       = ctrl.eeprom_wp;
    assign cmd_ready = ctrl.cmd_ready;
    assign snd_intr  = ctrl.snd_intr;

endmodule

`default_nettype wire

/* design/status_capture.sv */
// status capture, stage two
// sticky adc overflow, host service-request note and the status word

`default_nettype none

`include "cpu_io_defines.svh"

module status_capture
    import cpu_io_pkg::*;
(
    input  logic         cpu_clk,
    input  logic         rx_orst,
    input  cpu_cmd_t     cmd,
    input  logic         adc_ovfl,
    input  logic         host_srq,
    input  logic         dna_data,
    output status_word_t status,
    output logic         srq_out
);

    logic overflow;
    logic srq_noted;

    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
        begin
            overflow  <= 1'b0;
            srq_noted <= 1'b0;
            srq_out   <= 1'b0;
        end
        else
        begin
            // sticky until reset
            overflow <= overflow | adc_ovfl;
            // on a read hand over the note and restart from the live request,
            // so a request arriving in the read cycle is kept
            if (cmd.get_srq)
            begin
                srq_out   <= srq_noted;
                srq_noted <= host_srq;
            end
            else
                srq_noted <= srq_noted | host_srq;
        end
    end

    always_comb
    begin
        status.overflow = overflow;
        status.reserved = 3'b000;
        status.fpga_ver = `FPGA_VER;
        // only the device-id bit is live in the user nibble
        status.user     = {3'b000, dna_data};
        status.fpga_id  = `FPGA_ID;
    end

endmodule

`default_nettype wire

/* design/cycle_counters.sv */
// cpu cycle counters, stage two
// free-running and gated 32-bit counters for profiling cpu load

`default_nettype none

`include "cpu_io_defines.svh"

module cycle_counters
    import cpu_io_pkg::*;
(
    input  logic                  cpu_clk,
    input  logic                  rx_orst,
    input  cpu_cmd_t              cmd,
    output logic [`CPU_CTR_W-1:0] ctr0,
    output logic [`CPU_CTR_W-1:0] ctr1
);

    // gate for ctr1
    logic ctr_en;

    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
        begin
            ctr0   <= '0;
            ctr1   <= '0;
            ctr_en <= 1'b0;
        end
        else
        begin
            // clear wins over counting
            if (cmd.ctr_clr)
            begin
                ctr0 <= '0;
                ctr1 <= '0;
            end
            else
            begin
                ctr0 <= ctr0 + 1'b1;
                if (ctr_en)
                    ctr1 <= ctr1 + 1'b1;
            end

            // enable and disable events
            if (cmd.ctr_ena)
                ctr_en <= 1'b1;
            else if (cmd.ctr_dis)
                ctr_en <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* design/par_read_mux.sv */
// parallel read mux, stage three
// picks the 16-bit word returned to the cpu and registers it

`default_nettype none

`include "cpu_io_defines.svh"

module par_read_mux
    import cpu_io_pkg::*;
(
    input  logic                  cpu_clk,
    input  logic                  rx_orst,
    input  cpu_cmd_t              cmd,
    input  status_word_t          status,
    input  logic [`CPU_CTR_W-1:0] ctr0,
    input  logic [`CPU_CTR_W-1:0] ctr1,
    input  logic [31:0]           adc_count,
    input  logic [`CPU_PAR_W-1:0] host_dout,
    output logic [`CPU_PAR_W-1:0] par
);

    logic [`CPU_PAR_W-1:0] host_q;
    logic [`CPU_PAR_W-1:0] par_d;

    // host data delayed to line up with the decode stage
    always_ff @(posedge cpu_clk)
    begin
        host_q <= host_dout;
    end

    // priority: counter lanes, adc halves, status, host
    always_comb
    begin
        if (cmd.get_adc_lo)
            par_d = adc_count[15:0];
        else if (cmd.get_adc_hi)
            par_d = adc_count[31:16];
        else if (cmd.get_status)
            par_d = status;
        else
            par_d = host_q;
        // lowest lane last so it wins
        for (int k = 3; k >= 0; k--)
        begin
            if (cmd.get_ctr[k])
                par_d = {ctr1[8*k +: 8], ctr0[8*k +: 8]};
        end
    end

    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
            par <= '0;
        else
            par <= par_d;
    end

endmodule

`default_nettype wire

/* design/cpu_io_top.sv */
// cpu io core top level
// wires the decode, state and read stages between the cpu register bus
// and the board pins, all on cpu_clk

`default_nettype none

`include "cpu_io_defines.svh"

module cpu_io_top
    import cpu_io_pkg::*;
(
    input  logic                  cpu_clk,
    input  logic                  rx_orst,
    // cpu register bus
    input  logic [`CPU_OP_W-1:0]  op,
    input  logic [`CPU_TOS_W-1:0] tos,
    input  logic                  rd_reg,
    input  logic                  rd_reg2,
    input  logic                  wr_reg,
    input  logic                  wr_evt2,
    output logic [`CPU_PAR_W-1:0] par,
    // receiver and host side
    input  logic                  host_srq,
    input  logic                  adc_ovfl,
    input  logic [31:0]           adc_count,
    input  logic [`CPU_PAR_W-1:0] host_dout,
    input  logic                  dna_data,
    output logic                  srq_out,
    // board pins
    output ser_bus_t              attn_bus,
    output ser_bus_t              gps_bus,
    output ser_bus_t              dna_bus,
    output logic                  adc_clken,
    output logic                  adc_stenl,
    output logic                  ewp,
    output logic                  cmd_ready,
    output logic                  snd_intr
);

    cpu_cmd_t              cmd;
    status_word_t          status;
    logic [`CPU_CTR_W-1:0] ctr0;
    logic [`CPU_CTR_W-1:0] ctr1;

    //////////////////////////////
    // decode
    //////////////////////////////

    cpu_cmd_decode cpu_cmd_decode_i (
        .cpu_clk (cpu_clk),
        .rx_orst (rx_orst),
        .op      (op),
        .tos     (tos),
        .rd_reg  (rd_reg),
        .rd_reg2 (rd_reg2),
        .wr_reg  (wr_reg),
        .wr_evt2 (wr_evt2),
        .cmd     (cmd)
    );

    //////////////////////////////
    // state
    //////////////////////////////

    // control word itself has no pin, only its decoded fields
    ctrl_reg_bank ctrl_reg_bank_i (
        .cpu_clk   (cpu_clk),
        .rx_orst   (rx_orst),
        .cmd       (cmd),
        .ctrl      (),
        .attn_bus  (attn_bus),
        .gps_bus   (gps_bus),
        .dna_bus   (dna_bus),
        .adc_clken (adc_clken),
        .adc_stenl (adc_stenl),
        .ewp       (ewp),
        .cmd_ready (cmd_ready),
        .snd_intr  (snd_intr)
    );

    status_capture status_capture_i (
        .cpu_clk  (cpu_clk),
        .rx_orst  (rx_orst),
        .cmd      (cmd),
        .adc_ovfl (adc_ovfl),
        .host_srq (host_srq),
        .dna_data (dna_data),
        .status   (status),
        .srq_out  (srq_out)
    );

    cycle_counters cycle_counters_i (
        .cpu_clk (cpu_clk),
        .rx_orst (rx_orst),
        .cmd     (cmd),
        .ctr0    (ctr0),
        .ctr1    (ctr1)
    );

    //////////////////////////////
    // read
    //////////////////////////////

    par_read_mux par_read_mux_i (
        .cpu_clk   (cpu_clk),
        .rx_orst   (rx_orst),
        .cmd       (cmd),
        .status    (status),
        .ctr0      (ctr0),
        .ctr1      (ctr1),
        .adc_count (adc_count),
        .host_dout (host_dout),
        .par       (par)
    );

endmodule

`default_nettype wire

/* sim/cpu_io_tb.sv */
// cpu io core testbench
// directed tests of reset state, control writes, status, service request,
// cycle counters and the parallel read mux

`default_nettype none

`include "cpu_io_defines.svh"

module cpu_io_tb;

    timeunit 1ns;
    timeprecision 100ps;

    // tests need about 600 cycles
    localparam int MAX_CYCLES = 2000;

    logic        cpu_clk;
    logic        rx_orst;
    logic [15:0] op;
    logic [31:0] tos;
    logic        rd_reg;
    logic        rd_reg2;
    logic        wr_reg;
    logic        wr_evt2;
    logic [15:0] par;
    logic        host_srq;
    logic        adc_ovfl;
    logic [31:0] adc_count;
    logic [15:0] host_dout;
    logic        dna_data;
    logic        srq_out;
    logic [2:0]  attn_bus;
    logic [2:0]  gps_bus;
    logic [2:0]  dna_bus;
    logic        adc_clken;
    logic        adc_stenl;
    logic        ewp;
    logic        cmd_ready;
    logic        snd_intr;

    int cycles    = 0;
    int checks    = 0;
    int errors    = 0;
    int test_errs = 0;

    cpu_io_top cpu_io_top_i (.*);

    always #5 cpu_clk = ~cpu_clk;

    // run limit
    always @(posedge cpu_clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout, run stopped after %0d cycles", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic logic [15:0] op_bit(input int idx);
        return 16'h1 << idx;
    endfunction

    // status layout from the msb down
    function automatic logic [15:0] status_exp(input logic ovf, input logic dna);
        return {ovf, 3'b000, `FPGA_VER, 3'b000, dna, `FPGA_ID};
    endfunction

    // clken, stenl, ewp, cmd_ready, snd_intr
    function automatic logic [4:0] pins_exp(input logic [12:0] w);
        return {w[`CTRL_OSC_EN], ~w[`CTRL_STEN], w[`CTRL_EEPROM_WP],
                w[`CTRL_CMD_READY], w[`CTRL_SND_INTR]};
    endfunction

    task automatic expect_equal(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
        checks++;
        assert (got === exp)
        else
        begin
            $display("FAILED at %0d ns: %s, got %0h expected %0h", $time, what, got, exp);
            errors++;
            test_errs++;
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s done, %0d errors", name, test_errs);
        test_errs = 0;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge cpu_clk);
    endtask

    // past the update edge and sampled mid-cycle
    task automatic settle();
        @(posedge cpu_clk);
        @(negedge cpu_clk);
    endtask

    task automatic apply_reset();
        @(posedge cpu_clk);
        rx_orst <= 1'b1;
        repeat (10) @(posedge cpu_clk);
        rx_orst <= 1'b0;
        @(negedge cpu_clk);
    endtask

    // one-cycle strobe on wr_reg, or on wr_evt2 for events
    task automatic bus_write(input logic [15:0] op_word, input logic [31:0] data,
                             input logic evt);
        @(posedge cpu_clk);
        op      <= op_word;
        tos     <= data;
        wr_reg  <= ~evt;
        wr_evt2 <= evt;
        @(posedge cpu_clk);
        op      <= '0;
        wr_reg  <= 1'b0;
        wr_evt2 <= 1'b0;
    endtask

    // strobes is {rd_reg2, rd_reg}
    task automatic bus_read(input logic [15:0] op_word, input logic [1:0] strobes,
                            output logic [15:0] data);
        @(posedge cpu_clk);
        op      <= op_word;
        rd_reg  <= strobes[0];
        rd_reg2 <= strobes[1];
        @(posedge cpu_clk);
        op      <= '0;
        rd_reg  <= 1'b0;
        rd_reg2 <= 1'b0;
        // decode then read register
        settle();
        data = par;
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////

    task automatic reset_and_status();
        logic [15:0] d;
        expect_equal({adc_clken, adc_stenl, ewp, cmd_ready, snd_intr}, 5'b01000,
                     "control pins after reset");
        expect_equal({attn_bus, gps_bus, dna_bus}, 9'h0, "serial buses after reset");
        expect_equal({srq_out, par}, 17'h0, "srq_out and par after reset");
        for (int b = 0; b < 2; b++)
        begin
            @(posedge cpu_clk);
            dna_data <= 1'(b);
            bus_read(op_bit(`OP_GET_STATUS), 2'b01, d);
            expect_equal(d, status_exp(1'b0, 1'(b)), "status word");
        end
        end_test("reset_and_status");
    endtask

    task automatic ctrl_write_routing();
        logic [12:0] w;
        logic [2:0]  ser;
        logic [8:0]  route;
        for (int sel = 0; sel < 4; sel++)
        begin
            repeat (3)
            begin
                w = 13'($urandom);
                w[`CTRL_SER_SEL_HI:`CTRL_SER_SEL_LO] = 2'(sel);
                ser = {w[`CTRL_SER_LE_CSN], w[`CTRL_SER_CLK], w[`CTRL_SER_DATA]};
                // only the selected target mirrors the serial bits
                route = '0;
                if (2'(sel) == `SER_ATTN)
                    route[8:6] = ser;
                if (2'(sel) == `SER_GPS)
                    route[5:3] = ser;
                if (2'(sel) == `SER_DNA)
                    route[2:0] = ser;
                bus_write(op_bit(`OP_SET_CTRL), {19'($urandom), w}, 1'b0);
                settle();
                expect_equal({adc_clken, adc_stenl, ewp, cmd_ready, snd_intr},
                             pins_exp(w), "control pins");
                expect_equal({attn_bus, gps_bus, dna_bus}, route, "serial routing");
            end
        end
        end_test("ctrl_write_routing");
    endtask

    task automatic sticky_overflow();
        logic [15:0] d;
        @(posedge cpu_clk);
        adc_ovfl <= 1'b1;
        @(posedge cpu_clk);
        adc_ovfl <= 1'b0;
        repeat (3)
        begin
            bus_read(op_bit(`OP_GET_STATUS), 2'b01, d);
            expect_equal(d, status_exp(1'b1, dna_data), "overflow held");
            wait_cycles(1 + $urandom % 5);
        end
        // only reset clears it
        apply_reset();
        bus_read(op_bit(`OP_GET_STATUS), 2'b01, d);
        expect_equal(d, status_exp(1'b0, dna_data), "overflow after reset");
        end_test("sticky_overflow");
    endtask

    task automatic srq_capture();
        logic [15:0] d;
        bus_read(op_bit(`OP_GET_SRQ), 2'b01, d);
        expect_equal(srq_out, 1'b0, "srq_out with no request");
        @(posedge cpu_clk);
        host_srq <= 1'b1;
        @(posedge cpu_clk);
        host_srq <= 1'b0;
        wait_cycles(2);
        bus_read(op_bit(`OP_GET_SRQ), 2'b01, d);
        expect_equal(srq_out, 1'b1, "srq_out after request");
        bus_read(op_bit(`OP_GET_SRQ), 2'b01, d);
        expect_equal(srq_out, 1'b0, "srq_out after second read");
        end_test("srq_capture");
    endtask

    task automatic cycle_counting();
        logic [15:0] v1;
        logic [15:0] v2;
        int          gap;
        bus_write(op_bit(`OP_CPU_CTR_CLR), '0, 1'b1);
        // back-to-back reads are 3 cycles apart
        gap = 4 + $urandom % 8;
        bus_read(op_bit(`OP_GET_CPU_CTR0), 2'b01, v1);
        wait_cycles(gap - 3);
        bus_read(op_bit(`OP_GET_CPU_CTR0), 2'b01, v2);
        expect_equal(8'(v2[7:0] - v1[7:0]), 8'(gap), "ctr0 step");
        expect_equal({v1[15:8], v2[15:8]}, 16'h0, "ctr1 before enable");
        for (int k = 1; k < 4; k++)
        begin
            bus_read(op_bit(`OP_GET_CPU_CTR0 + k), 2'b01, v1);
            expect_equal(v1, 16'h0, "upper counter lanes");
        end
        bus_write(op_bit(`OP_CPU_CTR_ENA), '0, 1'b1);
        bus_read(op_bit(`OP_GET_CPU_CTR0), 2'b01, v1);
        wait_cycles(gap - 3);
        bus_read(op_bit(`OP_GET_CPU_CTR0), 2'b01, v2);
        expect_equal(8'(v2[15:8] - v1[15:8]), 8'(gap), "ctr1 step while enabled");
        bus_write(op_bit(`OP_CPU_CTR_DIS), '0, 1'b1);
        bus_read(op_bit(`OP_GET_CPU_CTR0), 2'b01, v1);
        wait_cycles(gap);
        bus_read(op_bit(`OP_GET_CPU_CTR0), 2'b01, v2);
        expect_equal(v2[15:8], v1[15:8], "ctr1 after disable");
        // clear with ctr1 holding a count
        bus_write(op_bit(`OP_CPU_CTR_CLR), '0, 1'b1);
        bus_read(op_bit(`OP_GET_CPU_CTR0), 2'b01, v2);
        expect_equal(v2[15:8], 8'h0, "ctr1 after clear");
        expect_equal(v2[7:0] < v1[7:0], 1'b1, "ctr0 after clear");
        end_test("cycle_counting");
    endtask

    task automatic read_priority();
        logic [15:0] d;
        logic [15:0] h;
        logic [15:0] prev;
        @(posedge cpu_clk);
        adc_count <= $urandom;
        host_dout <= 16'($urandom) | 16'h1;
        bus_read(op_bit(`OP_GET_ADC_CTR0), 2'b10, d);
        expect_equal(d, adc_count[15:0], "adc count low half");
        bus_read(op_bit(`OP_GET_ADC_CTR1), 2'b10, d);
        expect_equal(d, adc_count[31:16], "adc count high half");
        // adc half beats status and status beats host data
        bus_read(op_bit(`OP_GET_ADC_CTR0) | op_bit(`OP_GET_STATUS), 2'b11, d);
        expect_equal(d, adc_count[15:0], "adc over status");
        bus_read(op_bit(`OP_GET_STATUS), 2'b01, d);
        expect_equal(d, status_exp(1'b0, dna_data), "status over host data");
        prev = host_dout;
        repeat (4)
        begin
            h = 16'($urandom);
            @(posedge cpu_clk);
            host_dout <= h;
            @(posedge cpu_clk);
            @(negedge cpu_clk);
            // one cycle in, the old word is still on par
            expect_equal(par, prev, "host data delay");
            settle();
            expect_equal(par, h, "host data passthrough");
            prev = h;
        end
        end_test("read_priority");
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial
    begin
        void'($urandom(32'h1aa528ef));
        cpu_clk   = 1'b0;
        rx_orst   = 1'b1;
        op        = '0;
        tos       = '0;
        rd_reg    = 1'b0;
        rd_reg2   = 1'b0;
        wr_reg    = 1'b0;
        wr_evt2   = 1'b0;
        host_srq  = 1'b0;
        adc_ovfl  = 1'b0;
        adc_count = '0;
        host_dout = '0;
        dna_data  = 1'b0;
        apply_reset();

        reset_and_status();
        ctrl_write_routing();
        sticky_overflow();
        srq_capture();
        cycle_counting();
        read_priority();

        $display("%0d checks, %0d errors, %0d cycles", checks, errors, cycles);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+design
design/cpu_io_pkg.sv
design/cpu_cmd_decode.sv
design/ctrl_reg_bank.sv
design/status_capture.sv
design/cycle_counters.sv
design/par_read_mux.sv
design/cpu_io_top.sv
sim/cpu_io_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the cpu io testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module cpu_io_tb -o cpu_io_sim
./obj_dir/cpu_io_sim | tee sim.log

if grep -q "Finished with no errors" sim.log; then
    exit 0
fi
exit 1
